//--- clk_div_top.f
hdl/clk_div_pkg.sv
hdl/clk_cfg_if.sv
hdl/clk_div_regs.sv
hdl/clock_divider_counter.sv
hdl/clk_period_meter.sv
hdl/clk_div_top.sv
tests/tb_clk_gen.sv
tests/tb_clk_div_top.sv

//--- hdl/clk_cfg_if.sv
`timescale 1ns/10ps
`default_nettype none

interface clk_cfg_if;

	logic [clk_div_pkg::DIV_W-1:0] div_value;
	logic                          div_load;  // One-cycle strobe.
	logic                          test_mode; // Pin OR control bit.
	logic [clk_div_pkg::DIV_W-1:0] period;
	logic                          period_valid;

	// Register block.
	modport regs_mp (
		output div_value, div_load, test_mode,
		input  period, period_valid
	);

	modport div_mp (
		input div_value, div_load, test_mode
	);

	modport meter_mp (
		input  div_load,
		output period, period_valid
	);

endinterface

`default_nettype wire

//--- hdl/clk_div_pkg.sv
`default_nettype none

package clk_div_pkg;

	// Shared widths ------------------------
	localparam int DIV_W  = 8;  // Ratio and measured period.
	localparam int ADDR_W = 4;  // APB address.
	localparam int DATA_W = 32; // APB data.

	// APB register offsets.
	typedef enum logic [ADDR_W-1:0] {
		REG_CTRL   = 4'h0,
		REG_STATUS = 4'h4
	} clk_reg_e;

	// Period meter states.
	typedef enum logic [1:0] {
		MEAS_IDLE, // Waiting for first edge after a load.
		MEAS_RUN,  // Counting to the next edge.
		MEAS_DONE  // Period held and valid.
	} meter_state_e;

endpackage

`default_nettype wire

//--- hdl/clk_div_regs.sv
`timescale 1ns/10ps
`default_nettype none

module clk_div_regs #(
	parameter logic [clk_div_pkg::DIV_W-1:0] DIV_INIT = 8'hFF
) (
	input  wire                              clk,
	input  wire                              rstn,
	input  wire                              psel_i,
	input  wire                              penable_i,
	input  wire                              pwrite_i,
	input  wire [clk_div_pkg::ADDR_W-1:0]    paddr_i,
	input  wire [clk_div_pkg::DATA_W-1:0]    pwdata_i,
	output logic [clk_div_pkg::DATA_W-1:0]   prdata_o,
	output logic                             pslverr_o,
	input  wire                              test_mode_i,
	clk_cfg_if.regs_mp                       cfg
);

	localparam int W = clk_div_pkg::DIV_W;

	clk_div_pkg::clk_reg_e reg_sel;
	logic                  access;
	logic                  acc_ok;
	logic                  ctrl_wr;
	logic [W-1:0]          ratio_q;
	logic                  test_bit_q;
	logic                  load_q;

	// Decode ------------------------------
	assign reg_sel = clk_div_pkg::clk_reg_e'(paddr_i);
	assign access  = psel_i & penable_i; // Access cycle.

	always_comb begin
		case (reg_sel)
			clk_div_pkg::REG_CTRL:   acc_ok = 1'b1;
			clk_div_pkg::REG_STATUS: acc_ok = ~pwrite_i; // Read only.
			default:                 acc_ok = 1'b0;
		endcase
	end

	assign pslverr_o = access & ~acc_ok;
	assign ctrl_wr   = access & pwrite_i & (reg_sel == clk_div_pkg::REG_CTRL);

	// Control register --------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			ratio_q    <= DIV_INIT;
			test_bit_q <= 1'b0;
			load_q     <= 1'b0;
		end else begin
			load_q <= ctrl_wr; // High in the cycle after the write.
			if (ctrl_wr) begin
				ratio_q    <= pwdata_i[W-1:0];
				test_bit_q <= pwdata_i[W];
			end
		end
	end

	assign cfg.div_value = ratio_q;
	assign cfg.div_load  = load_q;
	assign cfg.test_mode = test_mode_i | test_bit_q;

	// Read mux.
	always_comb begin
		prdata_o = '0;
		case (reg_sel)
			clk_div_pkg::REG_CTRL: begin
				prdata_o[W-1:0] = ratio_q;
				prdata_o[W]     = test_bit_q; // Stored bit, not the pin.
			end
			clk_div_pkg::REG_STATUS: begin
				prdata_o[W-1:0] = cfg.period;
				prdata_o[W]     = cfg.period_valid;
			end
			default: prdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/clk_div_top.sv
`timescale 1ns/10ps
`default_nettype none

module clk_div_top #(
	parameter bit                            BYPASS_INIT = 1'b1,
	parameter logic [clk_div_pkg::DIV_W-1:0] DIV_INIT    = 8'hFF
) (
	input  wire                            clk,
	input  wire                            rstn,
	input  wire                            psel_i,
	input  wire                            penable_i,
	input  wire                            pwrite_i,
	input  wire [clk_div_pkg::ADDR_W-1:0]  paddr_i,
	input  wire [clk_div_pkg::DATA_W-1:0]  pwdata_i,
	output wire [clk_div_pkg::DATA_W-1:0]  prdata_o,
	output wire                            pslverr_o,
	input  wire                            test_mode_i,
	output wire                            clk_out_o
);

	clk_cfg_if cfg ();

	wire clk_div; // Divider output, also measured.

	clk_div_regs #(
		.DIV_INIT (DIV_INIT)
	) u_regs (
		.clk         (clk),
		.rstn        (rstn),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.paddr_i     (paddr_i),
		.pwdata_i    (pwdata_i),
		.prdata_o    (prdata_o),
		.pslverr_o   (pslverr_o),
		.test_mode_i (test_mode_i),
		.cfg         (cfg.regs_mp)
	);

	clock_divider_counter #(
		.BYPASS_INIT (BYPASS_INIT),
		.DIV_INIT    (DIV_INIT)
	) u_div (
		.clk       (clk),
		.rstn      (rstn),
		.cfg       (cfg.div_mp),
		.clk_out_o (clk_div)
	);

	clk_period_meter u_meter (
		.clk   (clk),
		.rstn  (rstn),
		.clk_i (clk_div),
		.cfg   (cfg.meter_mp)
	);

	assign clk_out_o = clk_div;

endmodule

`default_nettype wire

//--- hdl/clk_period_meter.sv
`timescale 1ns/10ps
`default_nettype none

module clk_period_meter (
	input  wire          clk,
	input  wire          rstn,
	input  wire          clk_i,
	clk_cfg_if.meter_mp  cfg
);

	localparam int W = clk_div_pkg::DIV_W;

	clk_div_pkg::meter_state_e state;
	logic                      sync1;
	logic                      sync2;
	logic                      sync3;
	logic                      rise;
	logic [W-1:0]              cnt;
	logic [W-1:0]              period_q;

	// Edge detect --------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			sync1 <= 1'b0;
			sync2 <= 1'b0;
			sync3 <= 1'b0;
		end else if (cfg.div_load) begin
			sync1 <= 1'b0; // Drop edges of the old ratio.
			sync2 <= 1'b0;
			sync3 <= 1'b0;
		end else begin
			sync1 <= clk_i;
			sync2 <= sync1;
			sync3 <= sync2;
		end
	end

	assign rise = sync2 & ~sync3;

	// Period FSM.
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state    <= clk_div_pkg::MEAS_IDLE;
			cnt      <= '0;
			period_q <= '0;
		end else if (cfg.div_load) begin
			state    <= clk_div_pkg::MEAS_IDLE;
			cnt      <= '0;
			period_q <= '0;
		end else begin
			case (state)
				clk_div_pkg::MEAS_IDLE: begin
					if (rise) begin
						state <= clk_div_pkg::MEAS_RUN;
						cnt   <= W'(1);
					end
				end
				clk_div_pkg::MEAS_RUN: begin
					if (rise) begin
						period_q <= cnt;
						state    <= clk_div_pkg::MEAS_DONE;
					end else if (cnt != '1) begin
						cnt <= cnt + W'(1); // Saturates.
					end
				end
				clk_div_pkg::MEAS_DONE: state <= clk_div_pkg::MEAS_DONE; // Hold until load.
				default: state <= clk_div_pkg::MEAS_IDLE;
			endcase
		end
	end

	assign cfg.period       = period_q;
	assign cfg.period_valid = (state == clk_div_pkg::MEAS_DONE);

endmodule

`default_nettype wire

//--- hdl/clock_divider_counter.sv
`timescale 1ns/10ps
`default_nettype none

module clock_divider_counter #(
	parameter bit                            BYPASS_INIT = 1'b1,
	parameter logic [clk_div_pkg::DIV_W-1:0] DIV_INIT    = 8'hFF
) (
	input  wire        clk,
	input  wire        rstn,
	clk_cfg_if.div_mp  cfg,
	output wire        clk_out_o
);

	localparam int W = clk_div_pkg::DIV_W;

	// Terminal count and parity that match DIV_INIT.
	localparam logic [W-1:0] CNT_INIT = DIV_INIT[0] ? DIV_INIT - W'(1)
		: (DIV_INIT >> 1) - W'(1);

	logic [W-1:0] counter;
	logic [W-1:0] counter_next;
	logic [W-1:0] cnt_term;
	logic [W-1:0] term_odd;
	logic [W-1:0] term_even;
	logic [W-1:0] half_cnt;
	logic         en1;
	logic         en2;
	logic         is_odd;
	logic         bypass;
	logic         div1;
	logic         div2;
	logic         load_q;
	logic         div_xor;

	assign term_odd  = cfg.div_value - W'(1);         // Full period per toggle pair.
	assign term_even = (cfg.div_value >> 1) - W'(1);  // Half period.
	assign half_cnt  = (cnt_term >> 1) + W'(1);       // Midpoint for the odd stage.

	always_comb begin
		en1 = (counter == '0);

		if (counter == cnt_term)
			counter_next = '0;
		else
			counter_next = counter + W'(1);

		if (cfg.div_load)
			en2 = 1'b0;
		else
			en2 = (counter == half_cnt);
	end

	// Rising edge stage -------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			counter  <= '0;
			div1     <= 1'b0;
			bypass   <= BYPASS_INIT;
			cnt_term <= CNT_INIT;
			is_odd   <= DIV_INIT[0];
			load_q   <= 1'b0;
		end else begin
			load_q <= cfg.div_load;
			if (cfg.div_load) begin
				counter <= '0;
				div1    <= 1'b0; // Restart from low.
				if (cfg.div_value < W'(2)) begin
					bypass   <= 1'b1;
					cnt_term <= '0;
					is_odd   <= 1'b0;
				end else begin
					bypass <= 1'b0;
					is_odd <= cfg.div_value[0];
					if (cfg.div_value[0])
						cnt_term <= term_odd;
					else
						cnt_term <= term_even;
				end
			end else if (!bypass) begin
				counter <= counter_next;
				if (en1)
					div1 <= ~div1;
			end
		end
	end

	// Falling edge stage for odd ratios.
	always_ff @(negedge clk or negedge rstn) begin
		if (!rstn)
			div2 <= 1'b0;
		else if (load_q)
			div2 <= 1'b0;
		else if (en2 && is_odd && !bypass)
			div2 <= ~div2;
	end

	assign div_xor   = div1 ^ div2;
	assign clk_out_o = (bypass | cfg.test_mode) ? clk : div_xor;

endmodule

`default_nettype wire

//--- tests/tb_clk_div_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_div_top;

	localparam int DW         = clk_div_pkg::DIV_W;
	localparam int AW         = clk_div_pkg::ADDR_W;
	localparam int XW         = clk_div_pkg::DATA_W;
	localparam int HALF_NS    = 5;
	localparam int RST_CYCLES = 8;
	localparam int POLL_LIMIT = 600; // Cycles allowed per ratio.
	localparam int NUM_RATIOS = 35;  // Loads issued by the stimulus.
	localparam longint WATCHDOG_NS = (NUM_RATIOS * POLL_LIMIT + RST_CYCLES) * 2 * HALF_NS;
	localparam logic [DW-1:0] DIV_INIT = 8'hFF;

	wire           clk;
	wire           rstn;
	wire [XW-1:0]  prdata;
	wire           pslverr;
	wire           clk_out;
	logic          psel;
	logic          penable;
	logic          pwrite;
	logic [AW-1:0] paddr;
	logic [XW-1:0] pwdata;
	logic          test_mode;
	logic [DW-1:0] exp_val;
	int            req_cnt = 0;
	int            ack_cnt = 0;

	tb_clk_gen #(
		.HALF_NS    (HALF_NS),
		.RST_CYCLES (RST_CYCLES)
	) u_clk_gen (
		.clk  (clk),
		.rstn (rstn)
	);

	clk_div_top #(
		.BYPASS_INIT (1'b1),
		.DIV_INIT    (DIV_INIT)
	) UUT (
		.clk         (clk),
		.rstn        (rstn),
		.psel_i      (psel),
		.penable_i   (penable),
		.pwrite_i    (pwrite),
		.paddr_i     (paddr),
		.pwdata_i    (pwdata),
		.prdata_o    (prdata),
		.pslverr_o   (pslverr),
		.test_mode_i (test_mode),
		.clk_out_o   (clk_out)
	);

	// Expected period is zero whenever the output is bypassed.
	function automatic logic [DW-1:0] exp_period(input logic [DW-1:0] ratio,
		input logic test);
		if (test || ratio < DW'(2))
			return '0;
		return ratio;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "Run stopped at the first failure.");
	endtask

	// Compare tasks ------------------------
	task automatic cmp_data(input string name, input logic [XW-1:0] got,
		input logic [XW-1:0] exp);
		if (got !== exp)
			stop_run($sformatf("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
				$time, name, got, exp));
	endtask

	task automatic cmp_err(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("Error at %0t ns: %s is %b, expected %b",
				$time, name, got, exp));
	endtask

	task automatic cmp_period(input string name, input logic [DW-1:0] got,
		input logic [DW-1:0] exp);
		if (got !== exp)
			stop_run($sformatf("Error at %0t ns: %s is %0d, expected %0d",
				$time, name, got, exp));
	endtask

	task automatic cmp_clk(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("Error at %0t ns: %s is %b, expected %b",
				$time, name, got, exp));
	endtask

	// APB driver ---------------------------
	task automatic apb_access(input logic wr, input logic [AW-1:0] addr,
		input logic [XW-1:0] wdata, output logic [XW-1:0] rdata, output logic err);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		#(HALF_NS - 1); // Just before the completing edge.
		rdata = prdata;
		err   = pslverr;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [AW-1:0] addr, input logic [XW-1:0] wdata,
		output logic err);
		logic [XW-1:0] unused;
		apb_access(1'b1, addr, wdata, unused, err);
	endtask

	task automatic apb_read(input logic [AW-1:0] addr, output logic [XW-1:0] rdata,
		output logic err);
		apb_access(1'b0, addr, '0, rdata, err);
	endtask

	task automatic check_clock_follows();
		repeat (4) begin
			@(posedge clk);
			#2;
			cmp_clk("clk_out_o", clk_out, clk);
			@(negedge clk);
			#2;
			cmp_clk("clk_out_o", clk_out, clk);
		end
	endtask

	// Writes CTRL and hands the expected period to the checker.
	task automatic load_ratio(input logic [DW-1:0] ratio, input logic test_bit);
		logic [XW-1:0] wdata;
		logic          err;
		wdata         = '0;
		wdata[DW-1:0] = ratio;
		wdata[DW]     = test_bit;
		apb_write(clk_div_pkg::REG_CTRL, wdata, err);
		cmp_err("pslverr_o", err, 1'b0);
		exp_val = exp_period(ratio, test_bit | test_mode);
		req_cnt++;
		wait (ack_cnt == req_cnt);
	endtask

	// Checker ------------------------------
	initial begin : compare_proc
		logic [XW-1:0] status;
		logic          err;
		int            cycles;
		forever begin
			wait (req_cnt != ack_cnt);
			if (exp_val == '0) begin
				repeat (64) @(posedge clk); // Meter gets time to see edges.
				check_clock_follows();
				apb_read(clk_div_pkg::REG_STATUS, status, err);
				cmp_err("pslverr_o", err, 1'b0);
				cmp_data("prdata_o", status, '0);
			end else begin
				cycles = 0;
				status = '0;
				while (!status[DW] && cycles < POLL_LIMIT) begin
					apb_read(clk_div_pkg::REG_STATUS, status, err);
					cycles += 3;
				end
				if (!status[DW])
					stop_run($sformatf("No valid period within %0d cycles for ratio %0d.",
						POLL_LIMIT, exp_val));
				cmp_period("period", status[DW-1:0], exp_val);
			end
			ack_cnt++;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		stop_run("Watchdog expired before the tests completed.");
	end

	// Stimulus -----------------------------
	initial begin : stimulus
		logic [XW-1:0] rdata;
		logic          err;
		logic [DW-1:0] ratio;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		test_mode = 1'b0;
		exp_val   = '0;
		void'($urandom(32'he402_9040));
		wait (rstn === 1'b1);

		apb_read(clk_div_pkg::REG_CTRL, rdata, err);
		cmp_err("pslverr_o", err, 1'b0);
		cmp_data("prdata_o", rdata, XW'(DIV_INIT));
		apb_read(clk_div_pkg::REG_STATUS, rdata, err);
		cmp_err("pslverr_o", err, 1'b0);
		cmp_data("prdata_o", rdata, '0);
		check_clock_follows(); // Bypass out of reset.

		load_ratio(8'd2, 1'b0);
		load_ratio(8'd4, 1'b0);
		load_ratio(8'd16, 1'b0);
		load_ratio(8'd254, 1'b0);
		load_ratio(8'd3, 1'b0);
		load_ratio(8'd5, 1'b0);
		load_ratio(8'd255, 1'b0);
		repeat (20) begin
			ratio = DW'(2 + $urandom % 254);
			load_ratio(ratio, 1'b0);
		end

		// Bypass paths with a normal ratio after each.
		load_ratio(8'd0, 1'b0);
		load_ratio(8'd6, 1'b0);
		load_ratio(8'd1, 1'b0);
		load_ratio(8'd6, 1'b0);
		load_ratio(8'd6, 1'b1);
		load_ratio(8'd6, 1'b0);
		@(negedge clk);
		test_mode = 1'b1;
		load_ratio(8'd6, 1'b0);
		@(negedge clk);
		test_mode = 1'b0;
		load_ratio(8'd6, 1'b0);

		apb_write(4'h8, 32'h0000_0155, err);
		cmp_err("pslverr_o", err, 1'b1);
		apb_read(4'hC, rdata, err);
		cmp_err("pslverr_o", err, 1'b1);
		apb_write(clk_div_pkg::REG_STATUS, 32'h0000_01FF, err);
		cmp_err("pslverr_o", err, 1'b1);
		apb_read(clk_div_pkg::REG_CTRL, rdata, err);
		cmp_err("pslverr_o", err, 1'b0);
		cmp_data("prdata_o", rdata, 32'h0000_0006);

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
	parameter int HALF_NS    = 5,
	parameter int RST_CYCLES = 8
) (
	output logic clk,
	output logic rstn
);

	initial begin
		clk = 1'b0;
		forever #(HALF_NS) clk = ~clk;
	end

	initial begin
		rstn = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1; // Release away from the active edge.
	end

endmodule

`default_nettype wire
